/* source/dram_phy_pkg.sv */
/* shared widths, idle command and packed pin structs for the DRAM retiming layer
   referenced by scoped name from the RTL and the testbench */
package dram_phy_pkg;

    // pad data bits per clock edge
    localparam int DQ_WIDTH = 16;

    // controller word carries both edges of one clock
    localparam int WORD_WIDTH = 2 * DQ_WIDTH;

    // one mask and one strobe per byte lane
    localparam int BYTE_LANES = 2;

    // mask bits per controller word, both edges of every lane
    localparam int DQM_WIDTH = 2 * BYTE_LANES;

    // chip selects, and the number of clock enable copies
    localparam int RANKS = 2;

    localparam int BANK_WIDTH = 2;
    localparam int ADDR_WIDTH = 13;

    // command fields as seen on the DRAM pins, all active low except ba and a
    typedef struct packed {
        logic [RANKS-1:0]      s_n;
        logic                  ras_n;
        logic                  cas_n;
        logic                  we_n;
        logic [BANK_WIDTH-1:0] ba;
        logic [ADDR_WIDTH-1:0] a;
    } dram_cmd_t;

    // deselect on every rank, which the DRAM reads as no operation
    localparam dram_cmd_t CMD_IDLE = '{
        s_n:   {RANKS{1'b1}},
        ras_n: 1'b1,
        cas_n: 1'b1,
        we_n:  1'b1,
        ba:    '0,
        a:     '0
    };

    // write side of the controller for one clock
    typedef struct packed {
        logic [WORD_WIDTH-1:0] dq;
        logic [DQM_WIDTH-1:0]  dqm;
        logic                  dqoe;
        logic [BYTE_LANES-1:0] dqs_low;
        logic [BYTE_LANES-1:0] dqs_high;
    } dram_write_t;

    // the two edge values of the DQ pads
    typedef struct packed {
        logic [DQ_WIDTH-1:0] high;
        logic [DQ_WIDTH-1:0] low;
    } dq_pair_t;

    // per-lane values for the two halves of a clock
    typedef struct packed {
        logic [BYTE_LANES-1:0] high;
        logic [BYTE_LANES-1:0] low;
    } lane_pair_t;

endpackage

/* source/dram_command_retimer.sv */
/* command and clock enable retiming between the DDR controller and the pins
   hold stage plus pin stage for commands, one registered cke copy per rank */
module dram_command_retimer
(
    input  logic                                int_drm_clock_buffered,
    input  logic                                system_reset_in,

    input  dram_phy_pkg::dram_cmd_t             cmd_next,
    input  logic                                cke_next,

    output dram_phy_pkg::dram_cmd_t             cmd_pins,
    output logic [dram_phy_pkg::RANKS-1:0]      cke_pins
);

    // first stage, sampled from the controller
    dram_phy_pkg::dram_cmd_t cmd_hold;

    // both stages come out of reset at deselect
    always_ff @(posedge int_drm_clock_buffered or posedge system_reset_in)
    begin
        if (system_reset_in)
        begin
            cmd_hold <= dram_phy_pkg::CMD_IDLE;
        end
        else
        begin
            cmd_hold <= cmd_next;
        end
    end

    // pin stage, stands in for the later clock phase of the pad drive
    always_ff @(posedge int_drm_clock_buffered or posedge system_reset_in)
    begin
        if (system_reset_in)
        begin
            cmd_pins <= dram_phy_pkg::CMD_IDLE;
        end
        else
        begin
            cmd_pins <= cmd_hold;
        end
    end

    // cke takes a single stage, slow output
    // each rank gets its own flop so it can sit next to its pad
    for (genvar r = 0; r < dram_phy_pkg::RANKS; r++)
    begin : g_cke_rank
        logic cke_q;

        always_ff @(posedge int_drm_clock_buffered or posedge system_reset_in)
        begin
            if (system_reset_in)
            begin
                cke_q <= 1'b0;
            end
            else
            begin
                cke_q <= cke_next;
            end
        end

        assign cke_pins[r] = cke_q;
    end

endmodule

/* source/dq_pin_bank.sv */
/* DQ pad registers: splits the controller word into edge halves with the output
   enable, and merges the captured input halves back into one read word */
module dq_pin_bank
(
    input  logic                                    int_drm_clock_buffered,
    input  logic                                    system_reset_in,

    // write side from the controller
    input  logic [dram_phy_pkg::WORD_WIDTH-1:0]     dq_next,
    input  logic                                    dqoe_next,

    // values captured at the pads on the two edges
    input  dram_phy_pkg::dq_pair_t                  dq_in,

    output dram_phy_pkg::dq_pair_t                  dq_out,
    output logic                                    dq_oe,
    output logic [dram_phy_pkg::WORD_WIDTH-1:0]     read_word
);

    // edge halves of the controller word
    dram_phy_pkg::dq_pair_t dq_split;

    // upper half goes out while the clock is high
    assign dq_split.high = dq_next[dram_phy_pkg::WORD_WIDTH-1:dram_phy_pkg::DQ_WIDTH];
    assign dq_split.low  = dq_next[dram_phy_pkg::DQ_WIDTH-1:0];

    // write data registers
    always_ff @(posedge int_drm_clock_buffered or posedge system_reset_in)
    begin
        if (system_reset_in)
        begin
            dq_out <= '0;
        end
        else
        begin
            dq_out <= dq_split;
        end
    end

    // pads stay released until the controller asks to drive
    always_ff @(posedge int_drm_clock_buffered or posedge system_reset_in)
    begin
        if (system_reset_in)
        begin
            dq_oe <= 1'b0;
        end
        else
        begin
            dq_oe <= dqoe_next;
        end
    end

    // read capture
    // high edge data lands in the upper bits, same order as the write word
    always_ff @(posedge int_drm_clock_buffered or posedge system_reset_in)
    begin
        if (system_reset_in)
        begin
            read_word <= '0;
        end
        else
        begin
            read_word <= {dq_in.high, dq_in.low};
        end
    end

endmodule

/* source/dram_strobe_lanes.sv */
/* per byte lane data mask and data strobe registers for the DDR pads
   strobe enables follow the DQ enable with one flop per lane */
module dram_strobe_lanes
(
    input  logic                                    int_drm_clock_buffered,
    input  logic                                    system_reset_in,

    input  logic [dram_phy_pkg::DQM_WIDTH-1:0]      dqm_next,
    input  logic [dram_phy_pkg::BYTE_LANES-1:0]     dqs_low_next,
    input  logic [dram_phy_pkg::BYTE_LANES-1:0]     dqs_high_next,
    input  logic                                    dqoe_next,

    output dram_phy_pkg::lane_pair_t                dqm_out,
    output dram_phy_pkg::lane_pair_t                dqs_out,
    output logic [dram_phy_pkg::BYTE_LANES-1:0]     dqs_oe
);

    // mask bits 3..2 belong to the high half, 1..0 to the low half
    always_ff @(posedge int_drm_clock_buffered or posedge system_reset_in)
    begin
        if (system_reset_in)
        begin
            dqm_out <= '0;
        end
        else
        begin
            dqm_out.high <= dqm_next[dram_phy_pkg::DQM_WIDTH-1:dram_phy_pkg::BYTE_LANES];
            dqm_out.low  <= dqm_next[dram_phy_pkg::BYTE_LANES-1:0];
        end
    end

    // both strobe phases
    always_ff @(posedge int_drm_clock_buffered or posedge system_reset_in)
    begin
        if (system_reset_in)
        begin
            dqs_out <= '0;
        end
        else
        begin
            dqs_out.high <= dqs_high_next;
            dqs_out.low  <= dqs_low_next;
        end
    end

    // separate enable flop per lane, kept apart for pad placement
    for (genvar l = 0; l < dram_phy_pkg::BYTE_LANES; l++)
    begin : g_dqs_lane
        logic oe_q;

        always_ff @(posedge int_drm_clock_buffered or posedge system_reset_in)
        begin
            if (system_reset_in)
            begin
                oe_q <= 1'b0;
            end
            else
            begin
                oe_q <= dqoe_next;
            end
        end

        assign dqs_oe[l] = oe_q;
    end

endmodule

/* source/dram_phy_top.sv */
/* DRAM retiming layer between a DDR controller and its pads
   command path, DQ write and read capture, and mask and strobe lanes */
module dram_phy_top
(
    input  logic                                    int_drm_clock_buffered,
    input  logic                                    system_reset_in,

    // controller side, sampled every rising edge
    input  dram_phy_pkg::dram_cmd_t                 cmd_next,
    input  logic                                    cke_next,
    input  dram_phy_pkg::dram_write_t               wr_next,

    // captured pad input halves
    input  dram_phy_pkg::dq_pair_t                  dq_in,

    // pad side
    output dram_phy_pkg::dram_cmd_t                 cmd_pins,
    output logic [dram_phy_pkg::RANKS-1:0]          cke_pins,
    output dram_phy_pkg::dq_pair_t                  dq_out,
    output logic                                    dq_oe,
    output dram_phy_pkg::lane_pair_t                dqm_out,
    output dram_phy_pkg::lane_pair_t                dqs_out,
    output logic [dram_phy_pkg::BYTE_LANES-1:0]     dqs_oe,

    // read word back to the controller
    output logic [dram_phy_pkg::WORD_WIDTH-1:0]     read_word
);

    // command and clock enable, two stages and one stage
    dram_command_retimer u_cmd
    (
        .int_drm_clock_buffered (int_drm_clock_buffered),
        .system_reset_in        (system_reset_in),
        .cmd_next               (cmd_next),
        .cke_next               (cke_next),
        .cmd_pins               (cmd_pins),
        .cke_pins               (cke_pins)
    );

    // data word and its enable, plus the read capture
    dq_pin_bank u_dq
    (
        .int_drm_clock_buffered (int_drm_clock_buffered),
        .system_reset_in        (system_reset_in),
        .dq_next                (wr_next.dq),
        .dqoe_next              (wr_next.dqoe),
        .dq_in                  (dq_in),
        .dq_out                 (dq_out),
        .dq_oe                  (dq_oe),
        .read_word              (read_word)
    );

    // mask and strobe lanes share the same enable as dq
    dram_strobe_lanes u_strobe
    (
        .int_drm_clock_buffered (int_drm_clock_buffered),
        .system_reset_in        (system_reset_in),
        .dqm_next               (wr_next.dqm),
        .dqs_low_next           (wr_next.dqs_low),
        .dqs_high_next          (wr_next.dqs_high),
        .dqoe_next              (wr_next.dqoe),
        .dqm_out                (dqm_out),
        .dqs_out                (dqs_out),
        .dqs_oe                 (dqs_oe)
    );

endmodule

/* test/dram_phy_props.sv */
/* concurrent assertions on the pad side of the retiming layer
   bound into the top level from the testbench */
module dram_phy_props
(
    input  logic                                    int_drm_clock_buffered,
    input  logic                                    system_reset_in,
    input  dram_phy_pkg::dram_cmd_t                 cmd_pins,
    input  logic [dram_phy_pkg::RANKS-1:0]          cke_pins,
    input  logic                                    dq_oe,
    input  logic [dram_phy_pkg::BYTE_LANES-1:0]     dqs_oe
);

    // every rank deselected while reset is held
    idle_in_reset: assert property (@(posedge int_drm_clock_buffered)
        system_reset_in |-> cmd_pins == dram_phy_pkg::CMD_IDLE)
    else
        $error("command pins not idle during reset");

    // per-rank cke flops always carry the same value
    cke_copies_equal: assert property (@(posedge int_drm_clock_buffered)
        cke_pins == {dram_phy_pkg::RANKS{cke_pins[0]}})
    else
        $error("clock enable copies differ");

    // strobe enables follow the data enable
    dqs_oe_follows: assert property (@(posedge int_drm_clock_buffered)
        dqs_oe == {dram_phy_pkg::BYTE_LANES{dq_oe}})
    else
        $error("strobe enable differs from data enable");

endmodule

/* test/dram_phy_checker.sv */
/* reference model of the retiming layer, compared on every falling clock edge
   prints one count line per test and the totals once done is raised */
module dram_phy_checker
(
    input  logic                                    int_drm_clock_buffered,
    input  logic                                    system_reset_in,
    input  logic                                    done,

    input  dram_phy_pkg::dram_cmd_t                 cmd_next,
    input  logic                                    cke_next,
    input  dram_phy_pkg::dram_write_t               wr_next,
    input  dram_phy_pkg::dq_pair_t                  dq_in,

    input  dram_phy_pkg::dram_cmd_t                 cmd_pins,
    input  logic [dram_phy_pkg::RANKS-1:0]          cke_pins,
    input  dram_phy_pkg::dq_pair_t                  dq_out,
    input  logic                                    dq_oe,
    input  dram_phy_pkg::lane_pair_t                dqm_out,
    input  dram_phy_pkg::lane_pair_t                dqs_out,
    input  logic [dram_phy_pkg::BYTE_LANES-1:0]     dqs_oe,
    input  logic [dram_phy_pkg::WORD_WIDTH-1:0]     read_word,

    output logic                                    report_done,
    output int                                      check_total,
    output int                                      fail_total
);

    localparam int TESTS = 6;
    localparam int DQW = dram_phy_pkg::DQ_WIDTH;
    localparam int LANES = dram_phy_pkg::BYTE_LANES;

    int pass_count [TESTS] = '{default: 0};
    int fail_count [TESTS] = '{default: 0};
    logic reported = 1'b0;
    int checks_seen = 0;
    int fails_seen = 0;

    // model delay lines, valid is low while they still hold reset values
    dram_phy_pkg::dram_cmd_t    cmd_q1;
    dram_phy_pkg::dram_cmd_t    cmd_q2;
    logic                       cmd_v1;
    logic                       cmd_v2;
    logic                       cke_q;
    dram_phy_pkg::dram_write_t  wr_q;
    dram_phy_pkg::dq_pair_t     dq_in_q;
    logic                       one_v;

    assign report_done = reported;
    assign check_total = checks_seen;
    assign fail_total = fails_seen;

    function automatic string test_name(input int t);
        case (t)
            0:       return "reset_idle";
            1:       return "command_pipeline";
            2:       return "cke_copies";
            3:       return "write_split";
            4:       return "output_enables";
            default: return "read_capture";
        endcase
    endfunction

    task automatic compare(input int t, input string field,
                           input logic [63:0] exp_val, input logic [63:0] act_val);
        if (act_val !== exp_val)
        begin
            $display("CHECK FAILED %s %s: expected %h, actual %h",
                     test_name(t), field, exp_val, act_val);
            fail_count[t]++;
        end
        else
            pass_count[t]++;
    endtask

    task automatic print_report();
        for (int t = 0; t < TESTS; t++)
        begin
            $display("test %s: %0d passed, %0d failed",
                     test_name(t), pass_count[t], fail_count[t]);
            checks_seen += pass_count[t] + fail_count[t];
            fails_seen += fail_count[t];
        end
        $display("total: %0d checks, %0d passed, %0d failed",
                 checks_seen, checks_seen - fails_seen, fails_seen);
    endtask

    always @(negedge int_drm_clock_buffered)
    begin
        int t_cmd;
        int t_one;
        if (!reported)
        begin
            if (system_reset_in)
            begin
                cmd_q1 = dram_phy_pkg::CMD_IDLE;
                cmd_q2 = dram_phy_pkg::CMD_IDLE;
                cmd_v1 = 1'b0;
                cmd_v2 = 1'b0;
                cke_q = 1'b0;
                wr_q = '0;
                dq_in_q = '0;
                one_v = 1'b0;
            end
            t_cmd = cmd_v2 ? 1 : 0;
            t_one = one_v ? 1 : 0;

            compare(t_cmd, "cmd_pins", 64'(cmd_q2), 64'(cmd_pins));
            compare(t_one * 2, "cke_pins", 64'({dram_phy_pkg::RANKS{cke_q}}), 64'(cke_pins));
            // high half of the word goes to the high edge
            compare(t_one * 3, "dq_out",
                    64'({wr_q.dq[2*DQW-1 -: DQW], wr_q.dq[DQW-1:0]}), 64'(dq_out));
            compare(t_one * 3, "dqm_out",
                    64'({wr_q.dqm[2*LANES-1 -: LANES], wr_q.dqm[LANES-1:0]}), 64'(dqm_out));
            compare(t_one * 3, "dqs_out", 64'({wr_q.dqs_high, wr_q.dqs_low}), 64'(dqs_out));
            compare(t_one * 4, "dq_oe", 64'(wr_q.dqoe), 64'(dq_oe));
            compare(t_one * 4, "dqs_oe", 64'({LANES{wr_q.dqoe}}), 64'(dqs_oe));
            compare(t_one * 5, "read_word", 64'({dq_in_q.high, dq_in_q.low}), 64'(read_word));

            if (!system_reset_in)
            begin
                cmd_q2 = cmd_q1;
                cmd_v2 = cmd_v1;
                cmd_q1 = cmd_next;
                cmd_v1 = 1'b1;
                cke_q = cke_next;
                wr_q = wr_next;
                dq_in_q = dq_in;
                one_v = 1'b1;
            end
            if (done)
            begin
                print_report();
                reported = 1'b1;
            end
        end
    end

endmodule

/* test/tb_dram_phy.sv */
/* testbench top for the DRAM retiming layer
   drives seeded random controller traffic with two resets and prints the verdict */
module tb_dram_phy;

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 3;
    localparam int RUN_CYCLES = 400;
    localparam int TAIL_CYCLES = 50;
    localparam int WAIT_LIMIT = 20;

    localparam int CMD_BITS = $bits(dram_phy_pkg::dram_cmd_t);
    localparam int WR_BITS = $bits(dram_phy_pkg::dram_write_t);
    localparam int DQ_BITS = $bits(dram_phy_pkg::dq_pair_t);

    logic                                   int_drm_clock_buffered;
    logic                                   system_reset_in;
    logic                                   done;

    dram_phy_pkg::dram_cmd_t                cmd_next;
    logic                                   cke_next;
    dram_phy_pkg::dram_write_t              wr_next;
    dram_phy_pkg::dq_pair_t                 dq_in;

    dram_phy_pkg::dram_cmd_t                cmd_pins;
    logic [dram_phy_pkg::RANKS-1:0]         cke_pins;
    dram_phy_pkg::dq_pair_t                 dq_out;
    logic                                   dq_oe;
    dram_phy_pkg::lane_pair_t               dqm_out;
    dram_phy_pkg::lane_pair_t               dqs_out;
    logic [dram_phy_pkg::BYTE_LANES-1:0]    dqs_oe;
    logic [dram_phy_pkg::WORD_WIDTH-1:0]    read_word;

    logic                                   report_done;
    int                                     check_total;
    int                                     fail_total;

    integer                                 seed;
    bit                                     run_ok;

    dram_phy_top u_dut
    (
        .int_drm_clock_buffered (int_drm_clock_buffered),
        .system_reset_in        (system_reset_in),
        .cmd_next               (cmd_next),
        .cke_next               (cke_next),
        .wr_next                (wr_next),
        .dq_in                  (dq_in),
        .cmd_pins               (cmd_pins),
        .cke_pins               (cke_pins),
        .dq_out                 (dq_out),
        .dq_oe                  (dq_oe),
        .dqm_out                (dqm_out),
        .dqs_out                (dqs_out),
        .dqs_oe                 (dqs_oe),
        .read_word              (read_word)
    );

    dram_phy_checker u_chk
    (
        .int_drm_clock_buffered (int_drm_clock_buffered),
        .system_reset_in        (system_reset_in),
        .done                   (done),
        .cmd_next               (cmd_next),
        .cke_next               (cke_next),
        .wr_next                (wr_next),
        .dq_in                  (dq_in),
        .cmd_pins               (cmd_pins),
        .cke_pins               (cke_pins),
        .dq_out                 (dq_out),
        .dq_oe                  (dq_oe),
        .dqm_out                (dqm_out),
        .dqs_out                (dqs_out),
        .dqs_oe                 (dqs_oe),
        .read_word              (read_word),
        .report_done            (report_done),
        .check_total            (check_total),
        .fail_total             (fail_total)
    );

    bind dram_phy_top dram_phy_props u_props
    (
        .int_drm_clock_buffered (int_drm_clock_buffered),
        .system_reset_in        (system_reset_in),
        .cmd_pins               (cmd_pins),
        .cke_pins               (cke_pins),
        .dq_oe                  (dq_oe),
        .dqs_oe                 (dqs_oe)
    );

    initial
    begin
        int_drm_clock_buffered = 1'b0;
        forever #(CLK_PERIOD / 2) int_drm_clock_buffered = ~int_drm_clock_buffered;
    end

    // one fresh random value for every controller input
    task automatic drive_random();
        logic [127:0] r;
        r = {$random(seed), $random(seed), $random(seed), $random(seed)};
        cmd_next <= r[0 +: CMD_BITS];
        cke_next <= r[CMD_BITS];
        wr_next  <= r[CMD_BITS + 1 +: WR_BITS];
        dq_in    <= r[CMD_BITS + 1 + WR_BITS +: DQ_BITS];
    endtask

    // traffic keeps running while reset is held
    task automatic pulse_reset(output bit ok);
        int guard;
        @(posedge int_drm_clock_buffered);
        system_reset_in <= 1'b1;
        drive_random();
        for (int i = 1; i < RESET_CYCLES; i++)
        begin
            @(posedge int_drm_clock_buffered);
            drive_random();
        end
        @(posedge int_drm_clock_buffered);
        system_reset_in <= 1'b0;
        drive_random();
        guard = 0;
        while (system_reset_in !== 1'b0 && guard < WAIT_LIMIT)
        begin
            @(posedge int_drm_clock_buffered);
            drive_random();
            guard++;
        end
        ok = (system_reset_in === 1'b0);
        if (!ok)
            $display("timeout waiting for reset release");
    endtask

    task automatic random_cycles(input int count, output bit ok);
        int  cycles;
        time start_time;
        cycles = 0;
        start_time = $time;
        while (cycles < count
               && ($time - start_time) < 64'((count + WAIT_LIMIT) * CLK_PERIOD))
        begin
            @(posedge int_drm_clock_buffered);
            drive_random();
            cycles++;
        end
        ok = (cycles == count);
        if (!ok)
            $display("timeout while running %0d random cycles", count);
    endtask

    task automatic wait_report(output bit ok);
        int guard;
        guard = 0;
        while (report_done !== 1'b1 && guard < WAIT_LIMIT)
        begin
            @(posedge int_drm_clock_buffered);
            guard++;
        end
        ok = (report_done === 1'b1);
        if (!ok)
            $display("timeout waiting for the checker to report its counts");
    endtask

    initial
    begin
        seed = 32'hf41589dd;
        run_ok = 1'b1;
        system_reset_in <= 1'b1;
        done <= 1'b0;
        cmd_next <= dram_phy_pkg::CMD_IDLE;
        cke_next <= 1'b0;
        wr_next <= '0;
        dq_in <= '0;

        pulse_reset(run_ok);
        if (run_ok)
            random_cycles(RUN_CYCLES, run_ok);
        // second reset in the middle of traffic
        if (run_ok)
            pulse_reset(run_ok);
        if (run_ok)
            random_cycles(TAIL_CYCLES, run_ok);
        if (run_ok)
        begin
            @(posedge int_drm_clock_buffered);
            done <= 1'b1;
            wait_report(run_ok);
        end

        if (run_ok && fail_total == 0 && check_total > 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

/* tb.f */
source/dram_phy_pkg.sv
source/dram_command_retimer.sv
source/dq_pin_bank.sv
source/dram_strobe_lanes.sv
source/dram_phy_top.sv
test/dram_phy_props.sv
test/dram_phy_checker.sv
test/tb_dram_phy.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the DRAM PHY testbench with Verilator
# the verdict comes from searching sim.log for the fail message

cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log

verilator --binary --timing --assert -f tb.f --top-module tb_dram_phy \
    -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || echo "TESTS FAILED" >> sim.log

cat sim.log

grep -q "TESTS FAILED" sim.log \
    && { echo "simulation failed, see sim.log and build.log"; exit 1; } \
    || { echo "simulation passed"; exit 0; }
